/* rtl/pwm_pkg.sv */
package pwm_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Periods, thresholds and phase counters
    localparam int CNT_W  = 32;
    // Breathe ramp increment
    localparam int STEP_W = 12;

    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [STEP_W-1:0] step_t;

    ////////////////////////////////////////////////////////////
    // Channel mode and configuration
    ////////////////////////////////////////////////////////////

    // Encoding 3 is unused and treated as idle
    typedef enum logic [1:0] {
        MODE_IDLE     = 2'd0,
        MODE_STANDARD = 2'd1,
        MODE_BREATHE  = 2'd2
    } pwm_mode_t;

    // Per channel settings from the outside world
    typedef struct packed {
        pwm_mode_t mode;
        cnt_t      period;
        cnt_t      thr_a;
        cnt_t      thr_b;
        step_t     step;
    } pwm_cfg_t;

    // Ordered ramp bounds for the breathe duty
    typedef struct packed {
        cnt_t  duty_lo;
        cnt_t  duty_hi;
        logic  start_down;
        step_t step;
    } pwm_ramp_cfg_t;

endpackage

/* rtl/pwm_mode_ctrl.sv */
`timescale 1ns/1ps

module pwm_mode_ctrl (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pwm_pkg::pwm_cfg_t      cfg,
    output pwm_pkg::pwm_mode_t     mode,
    output logic                   restart,
    output pwm_pkg::pwm_ramp_cfg_t ramp_cfg
);

    // Requested mode after folding the unused code
    pwm_pkg::pwm_mode_t mode_next;
    // Threshold A strictly below threshold B
    logic               a_below_b;

    ////////////////////////////////////////////////////////////
    // Active mode tracking
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cfg.mode)
            pwm_pkg::MODE_STANDARD: mode_next = pwm_pkg::MODE_STANDARD;
            pwm_pkg::MODE_BREATHE:  mode_next = pwm_pkg::MODE_BREATHE;
            // Idle and the spare code 3
            default:                mode_next = pwm_pkg::MODE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mode <= pwm_pkg::MODE_IDLE;
        end else begin
            mode <= mode_next;
        end
    end

    // One cycle pulse on any mode change
    // Covers entry into either active mode and the drop to idle
    assign restart = (mode_next != mode);

    ////////////////////////////////////////////////////////////
    // Threshold ordering
    ////////////////////////////////////////////////////////////

    assign a_below_b = (cfg.thr_a < cfg.thr_b);

    // Low and high ramp bounds
    assign ramp_cfg.duty_lo    = a_below_b ? cfg.thr_a : cfg.thr_b;
    assign ramp_cfg.duty_hi    = a_below_b ? cfg.thr_b : cfg.thr_a;
    // Ramp falls first when A sits at or above B
    assign ramp_cfg.start_down = !a_below_b;
    assign ramp_cfg.step       = cfg.step;

endmodule

/* rtl/pwm_duty_ramp.sv */
`timescale 1ns/1ps

module pwm_duty_ramp (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pwm_pkg::pwm_mode_t     mode,
    input  logic                   restart,
    input  pwm_pkg::cnt_t          thr_a,
    input  pwm_pkg::pwm_ramp_cfg_t ramp_cfg,
    input  logic                   period_end,
    output pwm_pkg::cnt_t          duty
);

    // Breathe duty and its direction
    pwm_pkg::cnt_t              duty_q;
    logic                       dir_down_q;

    // One extra bit so the upward sum cannot wrap
    logic [pwm_pkg::CNT_W:0]    up_sum;
    pwm_pkg::cnt_t              step_ext;
    // Distance left above the low bound
    pwm_pkg::cnt_t              room_down;
    logic                       hit_hi;
    logic                       hit_lo;
    logic                       ramp_tick;

    ////////////////////////////////////////////////////////////
    // Saturating step arithmetic
    ////////////////////////////////////////////////////////////

    assign step_ext  = pwm_pkg::cnt_t'(ramp_cfg.step);
    assign up_sum    = {1'b0, duty_q} + {1'b0, step_ext};
    assign room_down = duty_q - ramp_cfg.duty_lo;

    // Upper clamp when the sum reaches the high bound
    assign hit_hi = (up_sum >= {1'b0, ramp_cfg.duty_hi});
    // Lower clamp before the subtraction can go below the low bound
    // First term guards room_down against wrap after a threshold change
    assign hit_lo = (duty_q <= ramp_cfg.duty_lo) || (step_ext >= room_down);

    // Once per period in breathe only
    assign ramp_tick = (mode == pwm_pkg::MODE_BREATHE) && period_end;

    ////////////////////////////////////////////////////////////
    // Duty register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            duty_q     <= '0;
            dir_down_q <= 1'b0;
        end else if (restart) begin
            // Preload on every mode change
            // Only breathe ever reads these back
            duty_q     <= thr_a;
            dir_down_q <= ramp_cfg.start_down;
        end else if (ramp_tick) begin
            if (!dir_down_q) begin
                if (hit_hi) begin
                    duty_q     <= ramp_cfg.duty_hi;
                    dir_down_q <= 1'b1;
                end else begin
                    duty_q <= up_sum[pwm_pkg::CNT_W-1:0];
                end
            end else begin
                if (hit_lo) begin
                    duty_q     <= ramp_cfg.duty_lo;
                    dir_down_q <= 1'b0;
                end else begin
                    duty_q <= duty_q - step_ext;
                end
            end
        end
    end

    // Standard mode tracks threshold A directly
    assign duty = (mode == pwm_pkg::MODE_STANDARD) ? thr_a : duty_q;

endmodule

/* rtl/pwm_period_counter.sv */
`timescale 1ns/1ps

module pwm_period_counter (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  pwm_pkg::pwm_mode_t mode,
    input  logic               restart,
    input  pwm_pkg::cnt_t      period,
    input  pwm_pkg::cnt_t      duty,
    output logic               period_end,
    output logic               pwm
);

    // Position inside the current period
    pwm_pkg::cnt_t phase_q;
    // Counting allowed this cycle
    logic          active;
    pwm_pkg::cnt_t last_phase;

    ////////////////////////////////////////////////////////////
    // Phase counter
    ////////////////////////////////////////////////////////////

    // Restart holds the phase at zero for one cycle
    assign active     = (mode != pwm_pkg::MODE_IDLE) && !restart;
    assign last_phase = period - pwm_pkg::cnt_t'(1);

    // Greater-or-equal also wraps a phase left high by a shorter period
    assign period_end = active && (phase_q >= last_phase);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            phase_q <= '0;
        end else if (!active || period_end) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + pwm_pkg::cnt_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered output
    ////////////////////////////////////////////////////////////

    // High phases come first in each period
    // Gating with restart makes the drop to idle take one cycle
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pwm <= 1'b0;
        end else begin
            pwm <= active && (phase_q < duty);
        end
    end

endmodule

/* rtl/pwm_top.sv */
`timescale 1ns/1ps

module pwm_top #(
    parameter int N_CH = 2
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  pwm_pkg::pwm_cfg_t [N_CH-1:0]   cfg_i,
    output logic              [N_CH-1:0]   pwm_o
);

    ////////////////////////////////////////////////////////////
    // One identical channel per index
    ////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch

        // Channel local wiring
        pwm_pkg::pwm_mode_t     mode;
        logic                   restart;
        pwm_pkg::pwm_ramp_cfg_t ramp_cfg;
        pwm_pkg::cnt_t          duty;
        logic                   period_end;

        // Mode tracking and threshold ordering
        pwm_mode_ctrl u_mode_ctrl (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .cfg      (cfg_i[ch]),
            .mode     (mode),
            .restart  (restart),
            .ramp_cfg (ramp_cfg)
        );

        // Duty source for standard and breathe
        pwm_duty_ramp u_duty_ramp (
            .clk_i      (clk_i),
            .rstn_i     (rstn_i),
            .mode       (mode),
            .restart    (restart),
            .thr_a      (cfg_i[ch].thr_a),
            .ramp_cfg   (ramp_cfg),
            .period_end (period_end),
            .duty       (duty)
        );

        // Phase count and output flop
        pwm_period_counter u_period_counter (
            .clk_i      (clk_i),
            .rstn_i     (rstn_i),
            .mode       (mode),
            .restart    (restart),
            .period     (cfg_i[ch].period),
            .duty       (duty),
            .period_end (period_end),
            .pwm        (pwm_o[ch])
        );

    end

endmodule

/* testbench/pwm_asserts.sv */
`timescale 1ns/1ps

module pwm_asserts (
    input logic               clk_i,
    input logic               rstn_i,
    input pwm_pkg::pwm_mode_t mode,
    input logic               restart,
    input pwm_pkg::cnt_t      period,
    input pwm_pkg::cnt_t      duty,
    input logic               period_end,
    input logic               pwm,
    input pwm_pkg::cnt_t      duty_lo,
    input pwm_pkg::cnt_t      duty_hi
);

    // One period end per period
    a_single_end: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (period_end && period >= 2) |=> !period_end)
        else $error("period_end high in two consecutive cycles");

    // Registered idle means idle was requested one cycle earlier
    // Output must already be low, so the restart gating is covered
    a_idle_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mode == pwm_pkg::MODE_IDLE) |-> !pwm)
        else $error("pwm high one cycle after idle was requested");

    // Breathe duty between the ordered thresholds
    // Restart cycle skipped, thresholds may already belong to the next mode
    a_duty_bounds: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mode == pwm_pkg::MODE_BREATHE && !restart) |-> (duty >= duty_lo && duty <= duty_hi))
        else $error("breathe duty outside the threshold bounds");

endmodule

/* testbench/pwm_checker.sv */
`timescale 1ns/1ps

module pwm_checker #(
    parameter int N_CH = 2
) (
    input  logic                         clk_i,
    input  pwm_pkg::pwm_cfg_t [N_CH-1:0] cfg_i,
    input  logic              [N_CH-1:0] pwm_o,
    output int                           err_cnt
);

    // Longest wait for a rising edge of one output
    localparam int EDGE_TIMEOUT = 64;

    initial begin
        err_cnt = 0;
    end

    ////////////////////////////////////////////////////////////
    // Reference duty rules
    ////////////////////////////////////////////////////////////

    // Breathe duty of the next period, clamped at both bounds
    task automatic next_duty(input int lo, input int hi, input int step,
                             inout int duty, inout bit down);
        if (!down) begin
            if (duty + step >= hi) begin
                duty = hi;
                down = 1'b1;
            end else begin
                duty = duty + step;
            end
        end else begin
            // Compare before subtracting, no underflow
            if (step >= duty - lo) begin
                duty = lo;
                down = 1'b0;
            end else begin
                duty = duty - step;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output checks, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    // Low from the first cycle after idle
    task automatic check_idle(input int ch, input int cycles);
        for (int i = 1; i <= cycles; i++) begin
            @(negedge clk_i);
            if (pwm_o[ch]) begin
                $display("[FAIL] t=%0t: channel %0d high %0d cycles into idle", $time, ch, i);
                err_cnt++;
            end
        end
    endtask

    // Fresh start checks the two cycle latency, otherwise just resync
    task automatic check_channel(input int ch, input int n_per, input bit fresh);
        pwm_pkg::pwm_cfg_t c;
        int                waited;
        int                period;
        int                step;
        int                duty;
        int                lo;
        int                hi;
        int                high_exp;
        int                high_got;
        int                bad;
        bit                down;
        bit                prev;
        bit                rose;
        c      = cfg_i[ch];
        period = int'(c.period);
        step   = int'(c.step);
        duty   = int'(c.thr_a);
        lo     = (c.thr_a < c.thr_b) ? int'(c.thr_a) : int'(c.thr_b);
        hi     = (c.thr_a < c.thr_b) ? int'(c.thr_b) : int'(c.thr_a);
        // Falling first when A is not below B
        down   = !(c.thr_a < c.thr_b);
        waited = 0;
        prev   = pwm_o[ch];
        rose   = 1'b0;
        while (!rose && waited < EDGE_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
            rose = pwm_o[ch] && !prev;
            prev = pwm_o[ch];
        end
        if (!rose) begin
            $display("Channel %0d output never rose within %0d cycles", ch, EDGE_TIMEOUT);
            err_cnt++;
        end else begin
            if (fresh && waited != 2) begin
                $display("[FAIL] t=%0t: channel %0d first rise after %0d cycles, expected 2",
                         $time, ch, waited);
                err_cnt++;
            end
            // One window per period, high cycles first
            for (int k = 0; k < n_per; k++) begin
                high_exp = (duty < period) ? duty : period;
                high_got = 0;
                bad      = 0;
                for (int i = 0; i < period; i++) begin
                    if (pwm_o[ch]) begin
                        high_got++;
                    end
                    if (pwm_o[ch] != (i < high_exp)) begin
                        bad++;
                    end
                    @(negedge clk_i);
                end
                if (bad != 0) begin
                    $display("[FAIL] t=%0t: channel %0d period %0d expected %0d of %0d high, %s",
                             $time, ch, k, high_exp, period, "shape or count wrong");
                    $display("       saw %0d high, %0d cycles out of place", high_got, bad);
                    err_cnt++;
                end
                if (c.mode == pwm_pkg::MODE_BREATHE) begin
                    next_duty(lo, hi, step, duty, down);
                end
            end
        end
    endtask

endmodule

/* testbench/pwm_tb.sv */
`timescale 1ns/1ps

module pwm_tb;

    localparam int N_CH        = 2;
    // Cycles an idle channel is watched in a test
    localparam int IDLE_CYCLES = 20;

    // Short mode names for the table
    localparam pwm_pkg::pwm_mode_t IDL = pwm_pkg::MODE_IDLE;
    localparam pwm_pkg::pwm_mode_t STD = pwm_pkg::MODE_STANDARD;
    localparam pwm_pkg::pwm_mode_t BRE = pwm_pkg::MODE_BREATHE;

    // One stimulus row
    typedef struct {
        pwm_pkg::pwm_cfg_t [N_CH-1:0] cfg;
        int                           n_per;
        // No idle gap, unchanged channels keep running
        bit                           keep;
        string                        name;
    } test_t;

    logic                         clk_i;
    logic                         rstn_i;
    pwm_pkg::pwm_cfg_t [N_CH-1:0] cfg_i;
    logic              [N_CH-1:0] pwm_o;
    int                           err_cnt;

    test_t      tests [$];
    logic [7:0] lfsr_q = 8'd58;

    ////////////////////////////////////////////////////////////
    // Clock, DUT, checker and assertions
    ////////////////////////////////////////////////////////////

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    pwm_top #(.N_CH(N_CH)) u_dut (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .cfg_i  (cfg_i),
        .pwm_o  (pwm_o)
    );

    pwm_checker #(.N_CH(N_CH)) u_chk (
        .clk_i   (clk_i),
        .cfg_i   (cfg_i),
        .pwm_o   (pwm_o),
        .err_cnt (err_cnt)
    );

    // Ramp bounds come from the sibling duty ramp instance
    bind pwm_period_counter pwm_asserts u_asserts (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .mode       (mode),
        .restart    (restart),
        .period     (period),
        .duty       (duty),
        .period_end (period_end),
        .pwm        (pwm),
        .duty_lo    (u_duty_ramp.ramp_cfg.duty_lo),
        .duty_hi    (u_duty_ramp.ramp_cfg.duty_hi)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // Gap of 1 to 8 cycles, one step per bit
    task automatic draw_gap(output int cycles);
        logic [2:0] bits;
        for (int b = 0; b < 3; b++) begin
            bits[b] = lfsr_q[0];
            lfsr_q  = lfsr_next(lfsr_q);
        end
        cycles = int'(bits) + 1;
    endtask

    function automatic pwm_pkg::pwm_cfg_t make_cfg(pwm_pkg::pwm_mode_t mode, int period,
                                                   int thr_a, int thr_b, int step);
        pwm_pkg::pwm_cfg_t c;
        c.mode   = mode;
        c.period = pwm_pkg::cnt_t'(period);
        c.thr_a  = pwm_pkg::cnt_t'(thr_a);
        c.thr_b  = pwm_pkg::cnt_t'(thr_b);
        c.step   = pwm_pkg::step_t'(step);
        return c;
    endfunction

    task automatic watch_channel(int ch, test_t t);
        if (t.cfg[ch].mode == pwm_pkg::MODE_IDLE) begin
            u_chk.check_idle(ch, IDLE_CYCLES);
        end else begin
            u_chk.check_channel(ch, t.n_per, !t.keep);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int gap;
        int err_before;
        int n_fail;
        rstn_i = 1'b0;
        cfg_i  = '0;
        n_fail = 0;

        // Rows hold {ch1, ch0} as (mode, period, thr_a, thr_b, step), periods, keep, name
        tests.push_back(test_t'{{make_cfg(IDL, 0, 0, 0, 0), make_cfg(IDL, 0, 0, 0, 0)},
                                0, 1'b0, "reset_idle"});
        tests.push_back(test_t'{{make_cfg(STD, 20, 15, 0, 0), make_cfg(STD, 8, 2, 0, 0)},
                                4, 1'b0, "std_quarter"});
        tests.push_back(test_t'{{make_cfg(STD, 5, 9, 0, 0), make_cfg(STD, 6, 6, 0, 0)},
                                3, 1'b0, "std_full"});
        tests.push_back(test_t'{{make_cfg(STD, 10, 1, 0, 0), make_cfg(STD, 2, 1, 0, 0)},
                                5, 1'b0, "std_short"});
        tests.push_back(test_t'{{make_cfg(BRE, 12, 4, 12, 4), make_cfg(BRE, 16, 2, 10, 3)},
                                10, 1'b0, "breathe_rise"});
        tests.push_back(test_t'{{make_cfg(BRE, 10, 9, 2, 4), make_cfg(BRE, 20, 15, 3, 5)},
                                8, 1'b0, "breathe_fall"});
        tests.push_back(test_t'{{make_cfg(BRE, 9, 1, 8, 2), make_cfg(STD, 7, 3, 0, 0)},
                                6, 1'b0, "mixed_modes"});
        tests.push_back(test_t'{{make_cfg(IDL, 0, 0, 0, 0), make_cfg(STD, 7, 3, 0, 0)},
                                4, 1'b1, "drop_to_idle"});

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        foreach (tests[i]) begin
            err_before = err_cnt;
            // Idle gap puts every channel back to a known start
            if (!tests[i].keep) begin
                draw_gap(gap);
                cfg_i = '0;
                fork
                    u_chk.check_idle(0, gap);
                    u_chk.check_idle(1, gap);
                join
            end
            cfg_i = tests[i].cfg;
            fork
                watch_channel(0, tests[i]);
                watch_channel(1, tests[i]);
            join
            if (err_cnt == err_before) begin
                $display("test %0d %s: ok", i, tests[i].name);
            end else begin
                n_fail++;
                $display("test %0d %s: failed with %0d errors", i, tests[i].name,
                         err_cnt - err_before);
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests.size(), tests.size() - n_fail, n_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
rtl/pwm_pkg.sv
rtl/pwm_mode_ctrl.sv
rtl/pwm_duty_ramp.sv
rtl/pwm_period_counter.sv
rtl/pwm_top.sv
testbench/pwm_asserts.sv
testbench/pwm_checker.sv
testbench/pwm_tb.sv

/* Makefile */
# Verilator build and run for the PWM generator

VERILATOR ?= verilator
TOP       ?= pwm_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# A run that stops early never prints the pass line, so it fails as well
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
